/* rtl/spcAluPkg.sv */
`default_nettype none

package spcAluPkg;

  typedef enum logic [4:0] {
    OP_OR, OP_AND, OP_EOR, OP_TCLR1, OP_TSET1,
    OP_ASL, OP_ROL, OP_LSR, OP_ROR,
    OP_INC, OP_DEC, OP_ADC, OP_SBC,
    OP_DAA, OP_DAS, OP_XCN,
    OP_ADDW, OP_SUBW, OP_INCW, OP_DECW,
    OP_MUL, OP_DIV
  } aluOp_e;

  typedef enum logic [2:0] {
    IDLE, BYTE, WORDLO, WORDHI, ITER, FINISH
  } seqState_e;

  // Reshaping of the right operand ahead of the select stage
  typedef enum logic [2:0] {
    SHL0, ROLC, SHR0, RORC, ZERO, ONE, PASS, INVERT
  } preOp_e;

  typedef enum logic [3:0] {
    ORR, ANDR, XORR, PASSR,
    CLRBITS, SETBITS, SWAP,
    ADDC, SUBC,      // Carry in from C, or from the saved carry
    ADDN, SUBN,      // Fixed carry in
    DECADJ, DECSUB
  } postOp_e;

  localparam int mulSteps  = 8;
  localparam int divSteps  = 9;
  localparam int stepWidth = 4;

endpackage

`default_nettype wire

/* rtl/spcBcdAdjust.sv */
`timescale 1ns/1ps
`default_nettype none

module spcBcdAdjust (
  input  wire        [7:0] a,
  input  wire              subtract,
  input  wire              cIn,
  input  wire              hIn,
  output logic       [7:0] r,
  output logic             cOut
);

  logic       hiFix;
  logic       loFix;
  logic [7:0] adj;

  // For DAS the flags mean no borrow, so a clear flag asks for the fix
  always_comb begin
    hiFix = (subtract ? ~cIn : cIn) | (a > 8'h99);
    loFix = (subtract ? ~hIn : hIn) | (a[3:0] > 4'h9);
    adj   = {(hiFix ? 4'h6 : 4'h0), (loFix ? 4'h6 : 4'h0)};
    r     = subtract ? a - adj : a + adj;
    cOut  = hiFix ^ subtract;   // DAS clears C when it corrects
  end

endmodule

`default_nettype wire

/* rtl/spcByteAlu.sv */
`timescale 1ns/1ps
`default_nettype none

module spcByteAlu import spcAluPkg::*; (
  input  wire          CLK,
  input  wire          RST_N,
  input  wire          enable,
  input  wire preOp_e  pre,
  input  wire postOp_e post,
  input  wire          chgC,
  input  wire          chgV,
  input  wire          chgH,
  input  wire          w16,
  input  wire          useSavedC,
  input  wire    [7:0] left,
  input  wire    [7:0] right,
  input  wire          cIn,
  input  wire          vIn,
  input  wire          hIn,
  input  wire          zIn,
  output logic   [7:0] res,
  output logic         co,
  output logic         vo,
  output logic         ho,
  output logic         zo,
  output logic         so
);

  logic [7:0] preR;
  logic [7:0] addB;
  logic [7:0] addR;
  logic [7:0] bcdR;
  logic       preC;
  logic       addCin;
  logic       addC;
  logic       addH;
  logic       addV;
  logic       bcdC;
  logic       isAdd;
  logic       isSub;
  logic       cNew;
  logic       savedC;

  always_comb begin
    preR = right;
    preC = cIn;
    case (pre)
      SHL0: begin
        preR = {right[6:0], 1'b0};
        preC = right[7];
      end
      ROLC: begin
        preR = {right[6:0], cIn};
        preC = right[7];
      end
      SHR0: begin
        preR = {1'b0, right[7:1]};
        preC = right[0];
      end
      RORC: begin
        preR = {cIn, right[7:1]};
        preC = right[0];
      end
      ZERO:    preR = 8'h00;
      ONE:     preR = 8'h01;
      INVERT:  preR = ~right;
      default: preR = right;
    endcase
  end

  assign isSub  = (post == SUBC) || (post == SUBN);
  assign isAdd  = isSub || (post == ADDC) || (post == ADDN);
  assign addB   = isSub ? ~preR : preR;
  assign addCin = useSavedC ? savedC :
                  ((post == ADDC) || (post == SUBC)) ? cIn : (post == SUBN);
  assign {addC, addR} = {1'b0, left} + {1'b0, addB} + {8'h00, addCin};
  assign addH   = left[4] ^ addB[4] ^ addR[4];   // Carry into bit 4
  assign addV   = (left[7] == addB[7]) && (addR[7] != left[7]);

  spcBcdAdjust bcd_i (
    .a(left), .subtract(post == DECSUB), .cIn(cIn), .hIn(hIn),
    .r(bcdR), .cOut(bcdC)
  );

  always_comb begin
    cNew = preC;
    case (post)
      ORR:     res = left | preR;
      ANDR:    res = left & preR;
      XORR:    res = left ^ preR;
      CLRBITS: res = preR & ~left;
      SETBITS: res = preR | left;
      SWAP:    res = {preR[3:0], preR[7:4]};
      ADDC, SUBC, ADDN, SUBN: begin
        res  = addR;
        cNew = addC;
      end
      DECADJ, DECSUB: begin
        res  = bcdR;
        cNew = bcdC;
      end
      default: res = preR;
    endcase
  end

  // Chains the low pass carry into the high pass of a word op
  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      savedC <= 1'b0;
    end else if (enable && isAdd) begin
      savedC <= addC;
    end
  end

  assign co = chgC ? cNew : cIn;
  assign vo = chgV ? addV : vIn;
  assign ho = chgH ? addH : hIn;
  assign zo = (res == 8'h00) && (!w16 || zIn);   // Whole word Z on the high pass
  assign so = res[7];

  a_ctrlKnown: assert property (@(posedge CLK) disable iff (!RST_N)
    enable |-> !$isunknown({pre, post}));

endmodule

`default_nettype wire

/* rtl/spcStepCounter.sv */
`timescale 1ns/1ps
`default_nettype none

module spcStepCounter import spcAluPkg::*; (
  input  wire                 CLK,
  input  wire                 RST_N,
  input  wire                 load,
  input  wire [stepWidth-1:0] loadValue,
  output logic                last
);

  logic [stepWidth-1:0] count;

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      count <= '0;
    end else if (load) begin
      count <= loadValue;
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  assign last = (count == stepWidth'(1));

  // Previous run must have drained before a new item loads
  a_loadIdle: assert property (@(posedge CLK) disable iff (!RST_N)
    load |-> (count == '0));

endmodule

`default_nettype wire

/* rtl/spcMulDiv.sv */
`timescale 1ns/1ps
`default_nettype none

module spcMulDiv import spcAluPkg::*; (
  input  wire        CLK,
  input  wire        RST_N,
  input  wire        mdStart,
  input  wire        mdDiv,
  input  wire        step,
  input  wire [15:0] ya,
  input  wire  [7:0] x,
  output logic [7:0] mdHi,
  output logic [7:0] mdLo,
  output logic       mdV,
  output logic       mdH,
  output logic       mdN,
  output logic       mdZ
);

  logic [15:0] acc;     // Product, or dividend bits out and quotient bits in
  logic  [8:0] rem;     // Partial remainder; multiplier bits for MUL
  logic  [7:0] opnd;    // Multiplicand or divisor
  logic  [7:0] yHold;
  logic  [8:0] trial;
  logic        fits;
  logic        isDiv;
  logic        ovf;
  logic        nibGe;

  assign trial = {rem[7:0], acc[15]};
  assign fits  = trial >= {1'b0, opnd};

  always_ff @(posedge CLK) begin
    if (mdStart) begin
      opnd  <= mdDiv ? x : ya[15:8];
      yHold <= ya[15:8];
      if (mdDiv) begin
        rem <= 9'(ya >> divSteps);   // One step per quotient bit, nine in all
        acc <= ya << (16 - divSteps);
      end else begin
        rem <= {1'b0, ya[7:0]};
        acc <= '0;
      end
    end else if (step) begin
      if (isDiv) begin
        rem <= fits ? trial - {1'b0, opnd} : trial;
        acc <= {acc[14:0], fits};
      end else begin
        rem <= {rem[7:0], 1'b0};
        acc <= {acc[14:0], 1'b0} + (rem[7] ? {8'h00, opnd} : 16'h0000);
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      isDiv <= 1'b0;
      ovf   <= 1'b0;
      nibGe <= 1'b0;
    end else if (mdStart) begin
      isDiv <= mdDiv;
      ovf   <= ya[15:8] >= x;      // Also catches X = 0
      nibGe <= ya[11:8] >= x[3:0];
    end
  end

  always_comb begin
    if (isDiv) begin
      mdLo = ovf ? 8'hff : acc[7:0];
      mdHi = ovf ? yHold : rem[7:0];
    end else begin
      mdLo = acc[7:0];
      mdHi = acc[15:8];
    end
  end

  assign mdV = isDiv & ovf;
  assign mdH = isDiv & nibGe;
  assign mdN = isDiv ? mdLo[7] : mdHi[7];
  assign mdZ = isDiv ? (mdLo == 8'h00) : (mdHi == 8'h00);

endmodule

`default_nettype wire

/* rtl/spcAluSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module spcAluSequencer import spcAluPkg::*; (
  input  wire                  CLK,
  input  wire                  RST_N,
  input  wire                  start,
  input  wire aluOp_e          op,
  input  wire           [15:0] aIn,
  input  wire           [15:0] bIn,
  input  wire                  cIn,
  input  wire                  vIn,
  input  wire                  hIn,
  input  wire                  zIn,
  input  wire                  nIn,
  input  wire            [7:0] res,
  input  wire                  co,
  input  wire                  vo,
  input  wire                  ho,
  input  wire                  zo,
  input  wire                  so,
  input  wire                  last,
  input  wire            [7:0] mdHi,
  input  wire            [7:0] mdLo,
  input  wire                  mdV,
  input  wire                  mdH,
  input  wire                  mdN,
  input  wire                  mdZ,
  output preOp_e               pre,
  output postOp_e              post,
  output logic                 chgC,
  output logic                 chgV,
  output logic                 chgH,
  output logic                 w16,
  output logic                 useSavedC,
  output logic                 enable,
  output logic           [7:0] left,
  output logic           [7:0] right,
  output logic                 aluC,
  output logic                 aluV,
  output logic                 aluH,
  output logic                 aluZ,
  output logic                 load,
  output logic [stepWidth-1:0] loadValue,
  output logic                 mdStart,
  output logic                 mdDiv,
  output logic                 step,
  output logic          [15:0] result,
  output logic                 cOut,
  output logic                 vOut,
  output logic                 hOut,
  output logic                 zOut,
  output logic                 nOut,
  output logic                 busy,
  output logic                 done
);

  seqState_e   state;
  aluOp_e      opReg;
  logic [15:0] aReg;
  logic [15:0] bReg;
  logic        cReg;
  logic        vReg;
  logic        hReg;
  logic        zReg;
  logic        nReg;
  logic  [7:0] loByte;
  logic        loZ;
  logic        hiPass;
  logic        isWord;
  logic        isIter;
  logic        accept;
  logic        divOp;
  logic [15:0] finalResult;
  logic  [4:0] flagsNext;

  assign accept    = (state == IDLE) && start;   // Ignored while busy
  assign isWord    = op inside {OP_ADDW, OP_SUBW, OP_INCW, OP_DECW};
  assign isIter    = (op == OP_MUL) || (op == OP_DIV);
  assign hiPass    = (state == WORDHI);
  assign divOp     = (opReg == OP_DIV);
  assign enable    = (state == BYTE) || (state == WORDLO) || hiPass;
  assign w16       = hiPass;
  assign useSavedC = hiPass;
  assign aluC      = cReg;
  assign aluV      = vReg;
  assign aluH      = hReg;
  assign aluZ      = hiPass ? loZ : zReg;
  assign mdStart   = accept && isIter;
  assign mdDiv     = (op == OP_DIV);
  assign load      = mdStart;
  assign loadValue = mdDiv ? stepWidth'(divSteps) : stepWidth'(mulSteps);
  assign step      = (state == ITER);

  // Byte ALU control decode
  always_comb begin
    pre   = PASS;
    post  = PASSR;
    left  = hiPass ? aReg[15:8] : aReg[7:0];
    right = hiPass ? bReg[15:8] : bReg[7:0];
    chgC  = opReg inside {OP_ASL, OP_ROL, OP_LSR, OP_ROR, OP_ADC, OP_SBC,
                          OP_DAA, OP_DAS, OP_ADDW, OP_SUBW};
    chgV  = opReg inside {OP_ADC, OP_SBC, OP_ADDW, OP_SUBW, OP_INCW, OP_DECW};
    chgH  = chgV;
    if (opReg inside {OP_ASL, OP_ROL, OP_LSR, OP_ROR, OP_XCN}) begin
      right = aReg[7:0];   // Single operand ops
    end
    if (opReg inside {OP_INC, OP_DEC, OP_INCW, OP_DECW}) begin
      pre = ONE;
      if (hiPass) begin
        pre = ZERO;   // Only the carry ripples up
      end
    end
    case (opReg)
      OP_OR:    post = ORR;
      OP_AND:   post = ANDR;
      OP_EOR:   post = XORR;
      OP_TCLR1: post = CLRBITS;
      OP_TSET1: post = SETBITS;
      OP_ASL:   pre  = SHL0;
      OP_ROL:   pre  = ROLC;
      OP_LSR:   pre  = SHR0;
      OP_ROR:   pre  = RORC;
      OP_ADC:   post = ADDC;
      OP_SBC:   post = SUBC;
      OP_DAA:   post = DECADJ;
      OP_DAS:   post = DECSUB;
      OP_XCN:   post = SWAP;
      OP_INC, OP_ADDW, OP_INCW: begin
        post = ADDN;
        if (hiPass) begin
          post = ADDC;
        end
      end
      OP_DEC, OP_SUBW, OP_DECW: begin
        post = SUBN;
        if (hiPass) begin
          post = SUBC;
        end
      end
      default: ;
    endcase
  end

  always_comb begin
    flagsNext = {cReg, vReg, hReg, zReg, nReg};   // Hold unless the path updates
    if (state == FINISH) begin
      flagsNext = {cReg, (divOp ? mdV : vReg), (divOp ? mdH : hReg), mdZ, mdN};
    end else if ((state == BYTE) || hiPass) begin
      flagsNext = {co, vo, ho, zo, so};
    end
  end

  assign finalResult = (state == FINISH) ? {mdHi, mdLo} :
                       hiPass            ? {res, loByte} : {8'h00, res};

  always_ff @(posedge CLK) begin
    if (accept) begin
      opReg <= op;
      aReg  <= aIn;
      bReg  <= bIn;
      cReg  <= cIn;
      vReg  <= vIn;
      hReg  <= hIn;
      zReg  <= zIn;
      nReg  <= nIn;
    end
    if (state == WORDLO) begin
      loByte <= res;
      loZ    <= zo;
    end
  end

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      state  <= IDLE;
      busy   <= 1'b0;
      done   <= 1'b0;
      result <= '0;
      {cOut, vOut, hOut, zOut, nOut} <= '0;
    end else begin
      done <= 1'b0;
      case (state)
        IDLE: begin
          if (accept) begin
            busy <= 1'b1;
            if (isIter) begin
              state <= ITER;
            end else if (isWord) begin
              state <= WORDLO;
            end else begin
              state <= BYTE;
            end
          end
        end
        WORDLO: state <= WORDHI;
        ITER: begin
          if (last) begin
            state <= FINISH;
          end
        end
        default: begin   // BYTE, WORDHI and FINISH all complete here
          state  <= IDLE;
          busy   <= 1'b0;
          done   <= 1'b1;
          result <= finalResult;
          {cOut, vOut, hOut, zOut, nOut} <= flagsNext;
        end
      endcase
    end
  end

  a_donePulse: assert property (@(posedge CLK) disable iff (!RST_N)
    done |=> !done);

endmodule

`default_nettype wire

/* rtl/spcAluCore.sv */
`timescale 1ns/1ps
`default_nettype none

module spcAluCore import spcAluPkg::*; (
  input  wire          CLK,
  input  wire          RST_N,
  input  wire          start,
  input  wire aluOp_e  op,
  input  wire   [15:0] aIn,
  input  wire   [15:0] bIn,
  input  wire          cIn,
  input  wire          vIn,
  input  wire          hIn,
  input  wire          zIn,
  input  wire          nIn,
  output logic  [15:0] result,
  output logic         cOut,
  output logic         vOut,
  output logic         hOut,
  output logic         zOut,
  output logic         nOut,
  output logic         busy,
  output logic         done
);

  preOp_e               pre;
  postOp_e              post;
  logic                 chgC;
  logic                 chgV;
  logic                 chgH;
  logic                 w16;
  logic                 useSavedC;
  logic                 enable;
  logic           [7:0] left;
  logic           [7:0] right;
  logic                 aluC;
  logic                 aluV;
  logic                 aluH;
  logic                 aluZ;
  logic           [7:0] res;
  logic                 co;
  logic                 vo;
  logic                 ho;
  logic                 zo;
  logic                 so;
  logic                 load;
  logic [stepWidth-1:0] loadValue;
  logic                 last;
  logic                 mdStart;
  logic                 mdDiv;
  logic                 step;
  logic           [7:0] mdHi;
  logic           [7:0] mdLo;
  logic                 mdV;
  logic                 mdH;
  logic                 mdN;
  logic                 mdZ;

  spcAluSequencer seq_i (
    .CLK, .RST_N, .start, .op, .aIn, .bIn,
    .cIn, .vIn, .hIn, .zIn, .nIn,
    .res, .co, .vo, .ho, .zo, .so, .last,
    .mdHi, .mdLo, .mdV, .mdH, .mdN, .mdZ,
    .pre, .post, .chgC, .chgV, .chgH, .w16, .useSavedC, .enable,
    .left, .right, .aluC, .aluV, .aluH, .aluZ,
    .load, .loadValue, .mdStart, .mdDiv, .step,
    .result, .cOut, .vOut, .hOut, .zOut, .nOut, .busy, .done
  );

  spcByteAlu alu_i (
    .CLK, .RST_N, .enable, .pre, .post, .chgC, .chgV, .chgH,
    .w16, .useSavedC, .left, .right,
    .cIn(aluC), .vIn(aluV), .hIn(aluH), .zIn(aluZ),
    .res, .co, .vo, .ho, .zo, .so
  );

  spcStepCounter cnt_i (
    .CLK, .RST_N, .load, .loadValue, .last
  );

  // YA and X come straight from the ports, sampled with mdStart
  spcMulDiv md_i (
    .CLK, .RST_N, .mdStart, .mdDiv, .step,
    .ya(aIn), .x(bIn[7:0]),
    .mdHi, .mdLo, .mdV, .mdH, .mdN, .mdZ
  );

endmodule

`default_nettype wire

/* bench/aluChecker.sv */
`timescale 1ns/1ps
`default_nettype none

module aluChecker import spcAluPkg::*; (
  input  wire          CLK,
  input  wire          RST_N,
  input  wire          start,
  input  wire aluOp_e  op,
  input  wire   [15:0] aIn,
  input  wire   [15:0] bIn,
  input  wire          cIn,
  input  wire          vIn,
  input  wire          hIn,
  input  wire          zIn,
  input  wire          nIn,
  input  wire   [15:0] result,
  input  wire          cOut,
  input  wire          vOut,
  input  wire          hOut,
  input  wire          zOut,
  input  wire          nOut,
  input  wire          busy,
  input  wire          done,
  input  wire   [95:0] testName,
  output int           valueErrors,
  output int           protocolErrors
);

  logic [20:0] expected;
  logic [20:0] actual;
  logic [95:0] pendName;
  logic        pending;
  int          waited;
  int          latency;

  // Result and flags {result, C, V, H, Z, N} from the operation rules
  function automatic logic [20:0] predict(input aluOp_e o, input logic [15:0] a,
                                          input logic [15:0] b, input logic [4:0] f);
    logic [15:0] r;
    logic [15:0] addend;
    logic [16:0] sum;
    logic [12:0] hw;
    logic  [4:0] nib;
    logic [15:0] quot;
    logic [15:0] remd;
    logic  [7:0] y;
    logic  [7:0] x;
    logic        c;
    logic        v;
    logic        h;
    logic        z;
    logic        n;
    logic        cin;
    logic        hiFix;
    logic        loFix;
    {c, v, h, z, n} = f;
    y = a[15:8];
    x = b[7:0];
    r = 16'h0000;
    case (o)
      OP_OR:    r = {8'h00, a[7:0] | b[7:0]};
      OP_AND:   r = {8'h00, a[7:0] & b[7:0]};
      OP_EOR:   r = {8'h00, a[7:0] ^ b[7:0]};
      OP_TCLR1: r = {8'h00, b[7:0] & ~a[7:0]};   // A masks bits off the operand
      OP_TSET1: r = {8'h00, b[7:0] | a[7:0]};
      OP_XCN:   r = {8'h00, a[3:0], a[7:4]};
      OP_INC:   r = {8'h00, a[7:0] + 8'h01};
      OP_DEC:   r = {8'h00, a[7:0] - 8'h01};
      OP_ASL: begin
        r = {8'h00, a[6:0], 1'b0};
        c = a[7];
      end
      OP_ROL: begin
        r = {8'h00, a[6:0], c};
        c = a[7];
      end
      OP_LSR: begin
        r = {8'h00, 1'b0, a[7:1]};
        c = a[0];
      end
      OP_ROR: begin
        r = {8'h00, c, a[7:1]};
        c = a[0];
      end
      OP_ADC, OP_SBC: begin
        addend = (o == OP_SBC) ? {8'h00, ~b[7:0]} : {8'h00, b[7:0]};
        sum = {9'h000, a[7:0]} + {1'b0, addend} + {16'h0000, c};
        nib = {1'b0, a[3:0]} + {1'b0, addend[3:0]} + {4'h0, c};
        r = {8'h00, sum[7:0]};
        h = nib[4];
        v = (a[7] == addend[7]) && (sum[7] != a[7]);
        c = sum[8];
      end
      OP_DAA: begin
        hiFix = c || (a[7:0] > 8'h99);
        loFix = h || (a[3:0] > 4'h9);
        r = {8'h00, a[7:0] + (hiFix ? 8'h60 : 8'h00) + (loFix ? 8'h06 : 8'h00)};
        c = hiFix;
      end
      OP_DAS: begin
        hiFix = !c || (a[7:0] > 8'h99);
        loFix = !h || (a[3:0] > 4'h9);
        r = {8'h00, a[7:0] - (hiFix ? 8'h60 : 8'h00) - (loFix ? 8'h06 : 8'h00)};
        c = !hiFix;
      end
      OP_ADDW, OP_SUBW, OP_INCW, OP_DECW: begin
        addend = b;
        cin = 1'b0;
        if (o == OP_SUBW) begin
          addend = ~b;
          cin = 1'b1;
        end else if (o == OP_INCW) begin
          addend = 16'h0001;
        end else if (o == OP_DECW) begin
          addend = 16'hffff;   // Adding minus one
        end
        sum = {1'b0, a} + {1'b0, addend} + {16'h0000, cin};
        hw = {1'b0, a[11:0]} + {1'b0, addend[11:0]} + {12'h000, cin};
        r = sum[15:0];
        h = hw[12];
        v = (a[15] == addend[15]) && (r[15] != a[15]);
        if ((o == OP_ADDW) || (o == OP_SUBW)) begin
          c = sum[16];
        end
      end
      OP_MUL: r = {8'h00, y} * {8'h00, a[7:0]};
      OP_DIV: begin
        h = (y[3:0] >= x[3:0]);
        if (y >= x) begin
          r = {y, 8'hff};   // Overflow, X = 0 lands here too
          v = 1'b1;
        end else begin
          quot = a / {8'h00, x};
          remd = a % {8'h00, x};
          r = {remd[7:0], quot[7:0]};
          v = 1'b0;
        end
      end
      default: r = 16'h0000;
    endcase
    case (o)
      OP_ADDW, OP_SUBW, OP_INCW, OP_DECW: begin
        n = r[15];
        z = (r == 16'h0000);
      end
      OP_MUL: begin
        n = r[15];
        z = (r[15:8] == 8'h00);
      end
      default: begin   // Byte result, or the DIV quotient
        n = r[7];
        z = (r[7:0] == 8'h00);
      end
    endcase
    return {r, c, v, h, z, n};
  endfunction

  function automatic int latencyFor(input aluOp_e o);
    case (o)
      OP_ADDW, OP_SUBW, OP_INCW, OP_DECW: return 2;
      OP_MUL:  return mulSteps + 1;
      OP_DIV:  return divSteps + 1;
      default: return 1;
    endcase
  endfunction

  always @(posedge CLK) begin
    if (!RST_N) begin
      pending = 1'b0;
      waited = 0;
      valueErrors = 0;
      protocolErrors = 0;
    end else begin
      if (done) begin
        if (!pending) begin
          $display("ERROR: done pulsed with no operation in flight");
          protocolErrors++;
        end else begin
          actual = {result, cOut, vOut, hOut, zOut, nOut};
          if (actual !== expected) begin
            $display("FAIL %0s: expected result %h flags CVHZN %b, actual result %h flags %b",
                     pendName, expected[20:5], expected[4:0], actual[20:5], actual[4:0]);
            valueErrors++;
          end
          if (waited != latency) begin
            $display("FAIL %0s: expected done after %0d cycles, actual %0d",
                     pendName, latency, waited);
            protocolErrors++;
          end
          if (busy) begin
            $display("ERROR: busy still high when done pulsed for %0s", pendName);
            protocolErrors++;
          end
        end
        pending = 1'b0;
      end else if (pending) begin
        waited++;
        if (!busy) begin
          $display("ERROR: busy low while %0s was still running", pendName);
          protocolErrors++;
        end
        if (waited > latency + 2) begin
          $display("ERROR: no done for %0s after %0d cycles", pendName, waited);
          protocolErrors++;
          pending = 1'b0;
        end
      end
      // A start seen while busy is dropped by the DUT as well
      if (start && !busy) begin
        expected = predict(op, aIn, bIn, {cIn, vIn, hIn, zIn, nIn});
        latency = latencyFor(op);
        pendName = testName;
        pending = 1'b1;
        waited = 0;
      end
    end
  end

endmodule

`default_nettype wire

/* bench/tbAluCore.sv */
`timescale 1ns/1ps
`default_nettype none

module tbAluCore import spcAluPkg::*; ();

  logic        CLK = 1'b0;
  logic        RST_N;
  logic        start;
  aluOp_e      op;
  logic [15:0] aIn;
  logic [15:0] bIn;
  logic        cIn;
  logic        vIn;
  logic        hIn;
  logic        zIn;
  logic        nIn;
  logic [15:0] result;
  logic        cOut;
  logic        vOut;
  logic        hOut;
  logic        zOut;
  logic        nOut;
  logic        busy;
  logic        done;
  logic [95:0] testName;
  int          valueErrors;
  int          protocolErrors;
  int          cycles = 0;
  int          cycleLimit;
  int          rowCount;
  logic [31:0] seed;

  // Stimulus table with flags packed as {C, V, H, Z, N}
  logic [95:0] names    [0:79];
  aluOp_e      ops      [0:79];
  logic [15:0] aVals    [0:79];
  logic [15:0] bVals    [0:79];
  logic  [4:0] flagVals [0:79];
  logic        pokes    [0:79];   // Second start while busy

  always #50 CLK = ~CLK;

  spcAluCore dut_i (
    .CLK, .RST_N, .start, .op, .aIn, .bIn,
    .cIn, .vIn, .hIn, .zIn, .nIn,
    .result, .cOut, .vOut, .hOut, .zOut, .nOut, .busy, .done
  );

  aluChecker chk_i (
    .CLK, .RST_N, .start, .op, .aIn, .bIn,
    .cIn, .vIn, .hIn, .zIn, .nIn,
    .result, .cOut, .vOut, .hOut, .zOut, .nOut, .busy, .done,
    .testName, .valueErrors, .protocolErrors
  );

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic randWord(output logic [15:0] w);
    seed = lcgNext(seed);
    w = seed[31:16];
  endtask

  task automatic addRow(input logic [95:0] name, input aluOp_e o, input logic [15:0] a,
                        input logic [15:0] b, input logic [4:0] f, input logic poke);
    names[rowCount] = name;
    ops[rowCount] = o;
    aVals[rowCount] = a;
    bVals[rowCount] = b;
    flagVals[rowCount] = f;
    pokes[rowCount] = poke;
    rowCount++;
  endtask

  task automatic buildTable();
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] f;
    int          k;
    rowCount = 0;
    addRow("or", OP_OR, 16'h005a, 16'h00a5, 5'b10100, 1'b0);
    addRow("and", OP_AND, 16'h00f0, 16'h003c, 5'b01010, 1'b0);
    addRow("eor", OP_EOR, 16'h00ff, 16'h00ff, 5'b00001, 1'b0);
    addRow("tclr1", OP_TCLR1, 16'h000f, 16'h00ff, 5'b11100, 1'b0);
    addRow("tset1", OP_TSET1, 16'h0081, 16'h0010, 5'b00010, 1'b0);
    addRow("asl", OP_ASL, 16'h0081, 16'h0000, 5'b00000, 1'b0);
    addRow("rol", OP_ROL, 16'h0040, 16'h0000, 5'b10000, 1'b0);
    addRow("lsr", OP_LSR, 16'h0001, 16'h0000, 5'b00000, 1'b0);
    addRow("ror", OP_ROR, 16'h0002, 16'h0000, 5'b10000, 1'b0);
    addRow("xcn", OP_XCN, 16'h00c3, 16'h0000, 5'b11111, 1'b0);
    addRow("inc", OP_INC, 16'h00ff, 16'h0000, 5'b00000, 1'b0);
    addRow("dec", OP_DEC, 16'h0000, 16'h0000, 5'b10000, 1'b0);
    for (k = 0; k < 4; k++) begin   // All four C/H combinations
      addRow("daa", OP_DAA, {8'h00, 8'h19 + 8'h38 * k[7:0]}, 16'h0000,
             {k[1], 1'b0, k[0], 2'b00}, 1'b0);
      addRow("das", OP_DAS, {8'h00, 8'h0a + 8'h3c * k[7:0]}, 16'h0000,
             {k[1], 1'b0, k[0], 2'b00}, 1'b0);
    end
    addRow("addwZero", OP_ADDW, 16'h8000, 16'h8000, 5'b00000, 1'b0);
    addRow("addwLoZero", OP_ADDW, 16'h00ff, 16'h0001, 5'b00010, 1'b0);
    addRow("subwEqual", OP_SUBW, 16'h1234, 16'h1234, 5'b00000, 1'b0);
    addRow("subwBorrow", OP_SUBW, 16'h0100, 16'h0200, 5'b10000, 1'b0);
    addRow("incwOvf", OP_INCW, 16'h7fff, 16'h0000, 5'b10000, 1'b0);
    addRow("incwWrap", OP_INCW, 16'hffff, 16'h0000, 5'b00000, 1'b0);
    addRow("decwOvf", OP_DECW, 16'h8000, 16'h0000, 5'b00000, 1'b0);
    addRow("decwWrap", OP_DECW, 16'h0000, 16'h0000, 5'b10000, 1'b0);
    addRow("mulMax", OP_MUL, 16'hffff, 16'h0000, 5'b11100, 1'b0);
    addRow("mulZero", OP_MUL, 16'h0037, 16'h0000, 5'b00000, 1'b0);
    addRow("div", OP_DIV, 16'h1234, 16'h0056, 5'b11100, 1'b0);
    addRow("divOvf", OP_DIV, 16'h5634, 16'h0012, 5'b00000, 1'b0);
    addRow("divZero", OP_DIV, 16'h0345, 16'h0000, 5'b00000, 1'b0);
    addRow("divEqual", OP_DIV, 16'h4000, 16'h0040, 5'b10000, 1'b0);
    addRow("divBusy", OP_DIV, 16'h2f00, 16'h00c8, 5'b00000, 1'b1);
    for (k = 0; k < 4; k++) begin
      randWord(a);
      randWord(b);
      randWord(f);
      addRow("adcRand", OP_ADC, a, b, f[4:0], 1'b0);
      addRow("sbcRand", OP_SBC, b, a, f[9:5], 1'b0);
      addRow("incRand", OP_INC, a, b, f[14:10], 1'b0);
      addRow("decRand", OP_DEC, b, a, f[4:0], 1'b0);
      addRow("addwRand", OP_ADDW, a, b, f[9:5], 1'b0);
      addRow("subwRand", OP_SUBW, b, a, f[14:10], 1'b0);
      addRow("mulRand", OP_MUL, a, b, f[4:0], 1'b0);
      addRow("divRand", OP_DIV, b, a, f[9:5], 1'b0);
    end
  endtask

  task automatic applyRow(input int i);
    testName = names[i];
    op = ops[i];
    aIn = aVals[i];
    bIn = bVals[i];
    {cIn, vIn, hIn, zIn, nIn} = flagVals[i];
    start = 1'b1;
    @(negedge CLK);
    start = 1'b0;
    if (pokes[i]) begin
      @(negedge CLK);
      op = OP_ADC;   // Dropped while the DIV is still running
      aIn = ~aVals[i];
      bIn = 16'h0001;
      start = 1'b1;
      @(negedge CLK);
      start = 1'b0;
    end
    while (!done) begin
      @(negedge CLK);
    end
  endtask

  task automatic closeRun(input logic timedOut);
    $display("Errors: %0d value, %0d protocol, %0d timeout",
             valueErrors, protocolErrors, timedOut);
    if (timedOut || (valueErrors != 0) || (protocolErrors != 0)) begin
      $display("TESTS FAILED");
    end else begin
      $display("TESTS PASSED");
    end
    $finish;
  endtask

  always @(posedge CLK) begin
    cycles++;
    if (cycles > cycleLimit) begin
      $display("ERROR: run stopped after %0d cycles, the DUT did not finish", cycles);
      closeRun(1'b1);
    end
  end

  initial begin
    RST_N = 1'b0;
    start = 1'b0;
    op = OP_OR;
    aIn = 16'h0000;
    bIn = 16'h0000;
    {cIn, vIn, hIn, zIn, nIn} = 5'b00000;
    testName = "reset";
    seed = 32'haffe1bdb;
    buildTable();
    cycleLimit = rowCount * (divSteps + 4) + 20;
    repeat (8) @(negedge CLK);
    RST_N = 1'b1;
    for (int i = 0; i < rowCount; i++) begin
      applyRow(i);
    end
    repeat (4) @(negedge CLK);   // Room for a stray second done
    closeRun(1'b0);
  end

endmodule

`default_nettype wire

/* compile.f */
rtl/spcAluPkg.sv
rtl/spcBcdAdjust.sv
rtl/spcByteAlu.sv
rtl/spcStepCounter.sv
rtl/spcMulDiv.sv
rtl/spcAluSequencer.sv
rtl/spcAluCore.sv
bench/aluChecker.sv
bench/tbAluCore.sv
